// ==== src.f ====
+incdir+.
csr_pkg.sv
csr_irq.sv
csr_ctrl.sv
csr_regs.sv
csr_unit.sv
tb_csr_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_csr_unit -f src.f -o sim_csr_unit
./obj_dir/sim_csr_unit > sim.log
cat sim.log

if grep -qF "All tests passed!" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== tb_csr_unit.sv ====
// Self-checking testbench for the machine CSR unit against a reference model
`include "csr_defs.svh"

module tb_csr_unit;

    timeunit 1ns;
    timeprecision 100ps;

    // Six tests of at most 400 cycles each plus a margin
    localparam int CYCLE_LIMIT = 3000;

    logic                clk_i;
    logic                reset_i;
    logic                ena;
    logic                ex;
    logic                mret;
    csr_pkg::funct3_t    funct3;
    csr_pkg::csr_addr_t  addr;
    csr_pkg::xlen_t      src1;
    logic [4:0]          uimm;
    csr_pkg::cause_t     ex_cause;
    csr_pkg::xlen_t      pc;
    csr_pkg::xlen_t      tval;
    csr_pkg::irq_lines_t irq;

    logic                rdy;
    logic                err;
    logic                trap;
    csr_pkg::xlen_t      res;
    csr_pkg::xlen_t      trap_vec;
    csr_pkg::xlen_t      epc;

    // Reference copies of the stored CSRs
    logic                m_mie;
    logic                m_mpie;
    csr_pkg::xlen_t      m_mie_en;
    csr_pkg::xlen_t      m_mtvec;
    csr_pkg::xlen_t      m_mscratch;
    csr_pkg::xlen_t      m_mepc;
    csr_pkg::xlen_t      m_mcause;
    csr_pkg::xlen_t      m_mtval;

    integer seed;
    int     cycle_cnt;
    int     check_cnt;
    int     err_cnt;
    int     test_cnt;
    int     failed_tests;
    int     test_err_start;

    csr_unit csr_unit_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ena_i      (ena),
        .funct3_i   (funct3),
        .addr_i     (addr),
        .src1_i     (src1),
        .uimm_i     (uimm),
        .rdy_o      (rdy),
        .res_o      (res),
        .err_o      (err),
        .ex_i       (ex),
        .ex_cause_i (ex_cause),
        .pc_i       (pc),
        .tval_i     (tval),
        .mret_i     (mret),
        .irq_i      (irq),
        .trap_o     (trap),
        .trap_vec_o (trap_vec),
        .epc_o      (epc)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic known_addr(input logic [11:0] a);
        case (a)
            `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
            `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, `CSR_MVENDORID,
            `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Indices 0 to 6 are the writable registers and 9 to 12 the ID registers
    function automatic logic [11:0] known_at(input int i);
        case (i)
            0:  return `CSR_MSTATUS;
            1:  return `CSR_MIE;
            2:  return `CSR_MTVEC;
            3:  return `CSR_MSCRATCH;
            4:  return `CSR_MEPC;
            5:  return `CSR_MCAUSE;
            6:  return `CSR_MTVAL;
            7:  return `CSR_MISA;
            8:  return `CSR_MIP;
            9:  return `CSR_MVENDORID;
            10: return `CSR_MARCHID;
            11: return `CSR_MIMPID;
            default: return `CSR_MHARTID;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        case (a)
            // MPP is fixed at 11
            `CSR_MSTATUS:   return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
            `CSR_MISA:      return `CSR_MISA_VALUE;
            `CSR_MIE:       return m_mie_en;
            `CSR_MTVEC:     return m_mtvec;
            `CSR_MSCRATCH:  return m_mscratch;
            `CSR_MEPC:      return m_mepc;
            `CSR_MCAUSE:    return m_mcause;
            `CSR_MTVAL:     return m_mtval;
            `CSR_MIP:       return {20'd0, irq[2], 3'd0, irq[1], 3'd0, irq[0], 3'd0};
            `CSR_MVENDORID: return `CSR_MVENDORID_VALUE;
            `CSR_MARCHID:   return `CSR_MARCHID_VALUE;
            `CSR_MIMPID:    return `CSR_MIMPID_VALUE;
            `CSR_MHARTID:   return `CSR_MHARTID_VALUE;
            default:        return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] a, input logic [31:0] v);
        case (a)
            `CSR_MSTATUS: begin
                m_mie  = v[`CSR_MSTATUS_MIE];
                m_mpie = v[`CSR_MSTATUS_MPIE];
            end
            `CSR_MIE:      m_mie_en   = v & 32'h0000_0888;
            `CSR_MTVEC:    m_mtvec    = v & 32'hFFFF_FFFD;
            `CSR_MSCRATCH: m_mscratch = v;
            `CSR_MEPC:     m_mepc     = v & 32'hFFFF_FFFC;
            `CSR_MCAUSE:   m_mcause   = v;
            `CSR_MTVAL:    m_mtval    = v;
            default: ;
        endcase
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("ERR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Predict and compare mid-cycle before advancing the model and the clock
    task automatic step();
        logic [31:0] old_val;
        logic [31:0] opnd;
        logic [31:0] new_val;
        logic [31:0] base;
        logic [31:0] exp_res;
        logic [31:0] exp_vec;
        logic [2:0]  act;
        logic [4:0]  icause;
        logic        pend;
        logic        wr;
        logic        illegal;
        logic        exp_rdy;
        logic        exp_err;
        logic        exp_trap;
        #5;
        exp_rdy  = 1'b0;
        exp_err  = 1'b0;
        exp_trap = 1'b0;
        exp_res  = 32'd0;
        exp_vec  = 32'd0;
        old_val  = model_read(addr);
        base     = {m_mtvec[31:2], 2'b00};
        act[0]   = irq[0] & m_mie_en[`CSR_IRQ_MSI];
        act[1]   = irq[1] & m_mie_en[`CSR_IRQ_MTI];
        act[2]   = irq[2] & m_mie_en[`CSR_IRQ_MEI];
        pend     = m_mie && (act != 3'd0);
        icause   = act[2] ? 5'd11 : (act[0] ? 5'd3 : (act[1] ? 5'd7 : 5'd0));
        opnd     = funct3[2] ? {27'd0, uimm} : src1;
        wr       = 1'b0;
        new_val  = old_val;
        case (funct3)
            `CSR_F3_RW, `CSR_F3_RWI: begin
                wr      = 1'b1;
                new_val = opnd;
            end
            `CSR_F3_RS, `CSR_F3_RSI: begin
                wr      = (uimm != 5'd0);
                new_val = old_val | opnd;
            end
            `CSR_F3_RC, `CSR_F3_RCI: begin
                wr      = (uimm != 5'd0);
                new_val = old_val & ~opnd;
            end
            default: ;
        endcase
        illegal = (funct3 == 3'd0) || (funct3 == 3'd4) || !known_addr(addr)
                  || (wr && (addr[11:10] == 2'b11));
        if (ex) begin
            exp_trap = 1'b1;
            exp_vec  = base;
        end else if (!mret && ena) begin
            exp_rdy = 1'b1;
            exp_err = illegal;
            exp_res = old_val;
        end else if (!mret && pend) begin
            exp_trap = 1'b1;
            exp_vec  = m_mtvec[0] ? base + {25'd0, icause, 2'b00} : base;
        end
        check(32'(rdy), 32'(exp_rdy), "rdy_o");
        check(32'(err), 32'(exp_err), "err_o");
        check(32'(trap), 32'(exp_trap), "trap_o");
        check(res, exp_res, "res_o");
        check(trap_vec, exp_vec, "trap_vec_o");
        check(epc, m_mepc, "epc_o");
        if (exp_trap) begin
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mepc   = pc & 32'hFFFF_FFFC;
            m_mcause = ex ? {27'd0, ex_cause} : {1'b1, 26'd0, icause};
            m_mtval  = ex ? tval : 32'd0;
        end else if (mret) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end else if (ena && wr && !illegal) begin
            model_write(addr, new_val);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic access(input logic [2:0] f3, input logic [11:0] a,
                          input logic [31:0] s1, input logic [4:0] u);
        ena    = 1'b1;
        ex     = 1'b0;
        mret   = 1'b0;
        funct3 = f3;
        addr   = a;
        src1   = s1;
        uimm   = u;
        step();
        ena = 1'b0;
    endtask

    // Set form with a zero rs1 field reads without writing
    task automatic read_csr(input logic [11:0] a);
        access(`CSR_F3_RS, a, $random(seed), 5'd0);
    endtask

    task automatic idle();
        ena  = 1'b0;
        ex   = 1'b0;
        mret = 1'b0;
        pc   = $random(seed);
        step();
    endtask

    task automatic finish_test(input string name);
        test_cnt = test_cnt + 1;
        if (err_cnt == test_err_start) begin
            $display("Test %0d %s: ok", test_cnt, name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_start);
        end
        test_err_start = err_cnt;
    endtask

    task automatic run_write_test();
        int          i;
        logic [11:0] a;
        for (i = 0; i < 100; i++) begin
            a = known_at(rand_below(7));
            if (rand_below(2) == 0) begin
                access(`CSR_F3_RW, a, $random(seed), 5'(rand_below(32)));
            end else begin
                access(`CSR_F3_RWI, a, $random(seed), 5'(rand_below(32)));
            end
            read_csr(a);
        end
        finish_test("write and read back");
    endtask

    task automatic run_set_clear_test();
        int          i;
        logic [11:0] a;
        logic [4:0]  u;
        logic [2:0]  f3;
        for (i = 0; i < 100; i++) begin
            a  = known_at(rand_below(7));
            u  = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
            f3 = 3'(rand_below(2) + 2 + 4 * rand_below(2));
            access(f3, a, $random(seed), u);
            read_csr(a);
        end
        finish_test("set and clear forms");
    endtask

    task automatic run_illegal_test();
        int          i;
        logic [11:0] a;
        for (i = 0; i < 20; i++) begin
            a = known_at(rand_below(13));
            access((rand_below(2) == 0) ? 3'd0 : 3'd4, a, $random(seed), 5'(rand_below(32)));
        end
        for (i = 0; i < 20; i++) begin
            a = 12'($random(seed));
            while (known_addr(a)) begin
                a = 12'($random(seed));
            end
            access(`CSR_F3_RW, a, $random(seed), 5'(rand_below(32)));
        end
        // Writes to the ID registers by every write form with a nonzero field
        for (i = 0; i < 20; i++) begin
            a = known_at(9 + rand_below(4));
            access(3'(1 + rand_below(3) + 4 * rand_below(2)), a, $random(seed),
                   5'(1 + rand_below(31)));
        end
        for (i = 0; i < 20; i++) begin
            irq = 3'($random(seed));
            read_csr(known_at(7 + rand_below(6)));
        end
        irq = 3'd0;
        for (i = 0; i < 13; i++) begin
            read_csr(known_at(i));
        end
        finish_test("illegal accesses");
    endtask

    task automatic run_exception_test();
        int i;
        for (i = 0; i < 35; i++) begin
            if (i % 5 == 0) begin
                access(`CSR_F3_RW, `CSR_MTVEC, $random(seed), 5'd0);
            end
            access(`CSR_F3_RW, `CSR_MSTATUS, $random(seed), 5'd0);
            ex       = 1'b1;
            ex_cause = 5'($random(seed));
            pc       = $random(seed);
            tval     = $random(seed);
            step();
            ex = 1'b0;
            read_csr(`CSR_MEPC);
            read_csr(`CSR_MCAUSE);
            read_csr(`CSR_MTVAL);
            read_csr(`CSR_MSTATUS);
            mret = 1'b1;
            step();
            mret = 1'b0;
            read_csr(`CSR_MSTATUS);
        end
        finish_test("exception and return");
    endtask

    task automatic run_interrupt_test();
        int i;
        int k;
        for (i = 0; i < 40; i++) begin
            irq = 3'($random(seed));
            access(`CSR_F3_RW, `CSR_MIE, $random(seed), 5'd0);
            access(`CSR_F3_RW, `CSR_MSTATUS, $random(seed), 5'd0);
            access(`CSR_F3_RW, `CSR_MTVEC, $random(seed), 5'd0);
            for (k = 0; k < 4; k++) begin
                irq = 3'($random(seed));
                pc  = $random(seed);
                if (rand_below(3) == 0) begin
                    read_csr(known_at(rand_below(13)));
                end else begin
                    idle();
                end
            end
            read_csr(`CSR_MCAUSE);
        end
        irq = 3'd0;
        finish_test("interrupts");
    endtask

    task automatic run_priority_test();
        int i;
        for (i = 0; i < 300; i++) begin
            ex       = (rand_below(4) == 0);
            mret     = (rand_below(4) == 0);
            ena      = (rand_below(2) == 0);
            funct3   = 3'($random(seed));
            addr     = (rand_below(4) == 0) ? 12'($random(seed)) : known_at(rand_below(13));
            src1     = $random(seed);
            uimm     = 5'($random(seed));
            ex_cause = 5'($random(seed));
            pc       = $random(seed);
            tval     = $random(seed);
            irq      = 3'($random(seed));
            step();
        end
        ena  = 1'b0;
        ex   = 1'b0;
        mret = 1'b0;
        irq  = 3'd0;
        finish_test("request priority");
    endtask

    initial begin
        seed           = 97;
        cycle_cnt      = 0;
        check_cnt      = 0;
        err_cnt        = 0;
        test_cnt       = 0;
        failed_tests   = 0;
        test_err_start = 0;
        reset_i  = 1'b1;
        ena      = 1'b0;
        ex       = 1'b0;
        mret     = 1'b0;
        funct3   = 3'd0;
        addr     = 12'd0;
        src1     = 32'd0;
        uimm     = 5'd0;
        ex_cause = 5'd0;
        pc       = 32'd0;
        tval     = 32'd0;
        irq      = 3'd0;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mie_en   = 32'd0;
        m_mtvec    = 32'd0;
        m_mscratch = 32'd0;
        m_mepc     = 32'd0;
        m_mcause   = 32'd0;
        m_mtval    = 32'd0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        run_write_test();
        run_set_clear_test();
        run_illegal_test();
        run_exception_test();
        run_interrupt_test();
        run_priority_test();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_cnt, failed_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== csr_unit.sv ====
// Machine-mode CSR unit top connecting control, storage and interrupt logic
`include "csr_defs.svh"

module csr_unit (
    input  logic                clk_i,
    input  logic                reset_i,

    // Zicsr access
    input  logic                ena_i,
    input  csr_pkg::funct3_t    funct3_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      src1_i,
    input  logic [4:0]          uimm_i,
    output logic                rdy_o,
    output csr_pkg::xlen_t      res_o,
    output logic                err_o,

    // Exceptions and return
    input  logic                ex_i,
    input  csr_pkg::cause_t     ex_cause_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      tval_i,
    input  logic                mret_i,

    input  csr_pkg::irq_lines_t irq_i,

    output logic                trap_o,
    output csr_pkg::xlen_t      trap_vec_o,
    output csr_pkg::xlen_t      epc_o
);

    logic                csr_we;
    logic                trap_take;
    logic                trap_irq;
    logic                mret;
    csr_pkg::xlen_t      csr_wdat;
    csr_pkg::cause_t     trap_cause;

    csr_pkg::xlen_t      rd_dat;
    logic                rd_hit;
    logic                mstatus_mie;
    csr_pkg::xlen_t      mie_en;
    csr_pkg::xlen_t      mtvec;

    logic                irq_pend;
    csr_pkg::cause_t     irq_cause;
    csr_pkg::xlen_t      irq_vec;

    csr_ctrl csr_ctrl_i (
        .ena_i        (ena_i),
        .ex_i         (ex_i),
        .mret_i       (mret_i),
        .irq_pend_i   (irq_pend),
        .funct3_i     (funct3_i),
        .addr_i       (addr_i),
        .src1_i       (src1_i),
        .uimm_i       (uimm_i),
        .ex_cause_i   (ex_cause_i),
        .irq_cause_i  (irq_cause),
        .irq_vec_i    (irq_vec),
        .rd_dat_i     (rd_dat),
        .rd_hit_i     (rd_hit),
        .mtvec_i      (mtvec),
        .csr_we_o     (csr_we),
        .trap_take_o  (trap_take),
        .trap_irq_o   (trap_irq),
        .mret_o       (mret),
        .csr_wdat_o   (csr_wdat),
        .trap_cause_o (trap_cause),
        .rdy_o        (rdy_o),
        .err_o        (err_o),
        .trap_o       (trap_o),
        .res_o        (res_o),
        .trap_vec_o   (trap_vec_o)
    );

    csr_regs csr_regs_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_i       (addr_i),
        .we_i         (csr_we),
        .wdat_i       (csr_wdat),
        .trap_take_i  (trap_take),
        .trap_irq_i   (trap_irq),
        .mret_i       (mret),
        .trap_cause_i (trap_cause),
        .pc_i         (pc_i),
        .tval_i       (tval_i),
        .irq_i        (irq_i),
        .rd_dat_o     (rd_dat),
        .rd_hit_o     (rd_hit),
        .mie_o        (mstatus_mie),
        .mie_en_o     (mie_en),
        .mtvec_o      (mtvec),
        .mepc_o       (epc_o)
    );

    csr_irq csr_irq_i (
        .irq_i    (irq_i),
        .mie_i    (mstatus_mie),
        .mie_en_i (mie_en),
        .mtvec_i  (mtvec),
        .pend_o   (irq_pend),
        .cause_o  (irq_cause),
        .vec_o    (irq_vec)
    );

endmodule

// ==== csr_regs.sv ====
// Machine CSR storage with read multiplexer, masked writes and trap updates
`include "csr_defs.svh"

module csr_regs (
    input  logic                clk_i,
    input  logic                reset_i,

    input  csr_pkg::csr_addr_t  addr_i,
    input  logic                we_i,
    input  csr_pkg::xlen_t      wdat_i,

    input  logic                trap_take_i,
    input  logic                trap_irq_i,
    input  logic                mret_i,
    input  csr_pkg::cause_t     trap_cause_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      tval_i,

    input  csr_pkg::irq_lines_t irq_i,

    output csr_pkg::xlen_t      rd_dat_o,
    output logic                rd_hit_o,
    output logic                mie_o,
    output csr_pkg::xlen_t      mie_en_o,
    output csr_pkg::xlen_t      mtvec_o,
    output csr_pkg::xlen_t      mepc_o
);

    // Writable bits
    localparam csr_pkg::xlen_t mie_wmask = (csr_pkg::xlen_t'(1) << `CSR_IRQ_MSI)
                                         | (csr_pkg::xlen_t'(1) << `CSR_IRQ_MTI)
                                         | (csr_pkg::xlen_t'(1) << `CSR_IRQ_MEI);
    localparam csr_pkg::xlen_t mtvec_wmask = 32'hFFFF_FFFD;
    localparam csr_pkg::xlen_t mepc_wmask  = 32'hFFFF_FFFC;

    // Only the two enable bits of mstatus are stored
    logic           st_mie;
    logic           st_mpie;
    csr_pkg::xlen_t mie_q;
    csr_pkg::xlen_t mtvec_q;
    csr_pkg::xlen_t mscratch_q;
    csr_pkg::xlen_t mepc_q;
    csr_pkg::xlen_t mcause_q;
    csr_pkg::xlen_t mtval_q;

    csr_pkg::xlen_t mstatus_rd;
    csr_pkg::xlen_t mip_rd;

    always_comb begin
        mstatus_rd                    = '0;
        mstatus_rd[12:11]             = 2'b11;
        mstatus_rd[`CSR_MSTATUS_MPIE] = st_mpie;
        mstatus_rd[`CSR_MSTATUS_MIE]  = st_mie;
    end

    // Live view of the interrupt lines
    always_comb begin
        mip_rd               = '0;
        mip_rd[`CSR_IRQ_MSI] = irq_i[0];
        mip_rd[`CSR_IRQ_MTI] = irq_i[1];
        mip_rd[`CSR_IRQ_MEI] = irq_i[2];
    end

    // Read multiplexer
    always_comb begin
        rd_hit_o = 1'b1;
        case (addr_i)
            `CSR_MSTATUS:   rd_dat_o = mstatus_rd;
            `CSR_MISA:      rd_dat_o = `CSR_MISA_VALUE;
            `CSR_MIE:       rd_dat_o = mie_q;
            `CSR_MTVEC:     rd_dat_o = mtvec_q;
            `CSR_MSCRATCH:  rd_dat_o = mscratch_q;
            `CSR_MEPC:      rd_dat_o = mepc_q;
            `CSR_MCAUSE:    rd_dat_o = mcause_q;
            `CSR_MTVAL:     rd_dat_o = mtval_q;
            `CSR_MIP:       rd_dat_o = mip_rd;
            `CSR_MVENDORID: rd_dat_o = `CSR_MVENDORID_VALUE;
            `CSR_MARCHID:   rd_dat_o = `CSR_MARCHID_VALUE;
            `CSR_MIMPID:    rd_dat_o = `CSR_MIMPID_VALUE;
            `CSR_MHARTID:   rd_dat_o = `CSR_MHARTID_VALUE;
            default: begin
                rd_hit_o = 1'b0;
                rd_dat_o = '0;
            end
        endcase
    end

    // Trap entry and return win over an ordinary write
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            st_mie     <= 1'b0;
            st_mpie    <= 1'b0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (trap_take_i) begin
            st_mpie  <= st_mie;
            st_mie   <= 1'b0;
            mepc_q   <= pc_i & mepc_wmask;
            mcause_q <= {trap_irq_i, {(`CSR_XLEN-6){1'b0}}, trap_cause_i};
            // Interrupts carry no trap value
            mtval_q  <= trap_irq_i ? '0 : tval_i;
        end else if (mret_i) begin
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
        end else if (we_i) begin
            case (addr_i)
                `CSR_MSTATUS: begin
                    st_mie  <= wdat_i[`CSR_MSTATUS_MIE];
                    st_mpie <= wdat_i[`CSR_MSTATUS_MPIE];
                end
                `CSR_MIE:      mie_q      <= wdat_i & mie_wmask;
                `CSR_MTVEC:    mtvec_q    <= wdat_i & mtvec_wmask;
                `CSR_MSCRATCH: mscratch_q <= wdat_i;
                `CSR_MEPC:     mepc_q     <= wdat_i & mepc_wmask;
                `CSR_MCAUSE:   mcause_q   <= wdat_i;
                `CSR_MTVAL:    mtval_q    <= wdat_i;
                // misa and mip drop the write
                default: ;
            endcase
        end
    end

    assign mie_o    = st_mie;
    assign mie_en_o = mie_q;
    assign mtvec_o  = mtvec_q;
    assign mepc_o   = mepc_q;

endmodule

// ==== csr_ctrl.sv ====
// CSR access decode, new value formation, legality check and request arbitration
`include "csr_defs.svh"

module csr_ctrl (
    input  logic                ena_i,
    input  logic                ex_i,
    input  logic                mret_i,
    input  logic                irq_pend_i,

    input  csr_pkg::funct3_t    funct3_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      src1_i,
    input  logic [4:0]          uimm_i,
    input  csr_pkg::cause_t     ex_cause_i,

    input  csr_pkg::cause_t     irq_cause_i,
    input  csr_pkg::xlen_t      irq_vec_i,

    input  csr_pkg::xlen_t      rd_dat_i,
    input  logic                rd_hit_i,
    input  csr_pkg::xlen_t      mtvec_i,

    output logic                csr_we_o,
    output logic                trap_take_o,
    output logic                trap_irq_o,
    output logic                mret_o,
    output csr_pkg::xlen_t      csr_wdat_o,
    output csr_pkg::cause_t     trap_cause_o,

    output logic                rdy_o,
    output logic                err_o,
    output logic                trap_o,
    output csr_pkg::xlen_t      res_o,
    output csr_pkg::xlen_t      trap_vec_o
);

    logic grant_ex;
    logic grant_mret;
    logic grant_acc;
    logic grant_irq;

    logic f3_bad;
    logic wants_wr;
    logic read_only;
    logic illegal;

    csr_pkg::xlen_t operand;

    // Fixed priority: exception, return, access, interrupt
    assign grant_ex   = ex_i;
    assign grant_mret = ~ex_i & mret_i;
    assign grant_acc  = ~ex_i & ~mret_i & ena_i;
    assign grant_irq  = ~ex_i & ~mret_i & ~ena_i & irq_pend_i;

    // funct3 bit 2 selects the zero-extended rs1 field as operand
    assign operand = funct3_i[2] ? csr_pkg::xlen_t'(uimm_i) : src1_i;

    always_comb begin
        f3_bad     = 1'b0;
        wants_wr   = 1'b0;
        csr_wdat_o = rd_dat_i;

        case (funct3_i)
            `CSR_F3_RW, `CSR_F3_RWI: begin
                wants_wr   = 1'b1;
                csr_wdat_o = operand;
            end

            // Set and clear skip the write for a zero rs1 field
            `CSR_F3_RS, `CSR_F3_RSI: begin
                wants_wr   = (uimm_i != 5'd0);
                csr_wdat_o = rd_dat_i | operand;
            end

            `CSR_F3_RC, `CSR_F3_RCI: begin
                wants_wr   = (uimm_i != 5'd0);
                csr_wdat_o = rd_dat_i & ~operand;
            end

            default: begin
                f3_bad = 1'b1;
            end
        endcase
    end

    // Top address bits 11 mark a read-only CSR
    assign read_only = (addr_i[11:10] == 2'b11);
    assign illegal   = f3_bad | ~rd_hit_i | (wants_wr & read_only);

    // Access response
    assign rdy_o    = grant_acc;
    assign err_o    = grant_acc & illegal;
    assign res_o    = grant_acc ? rd_dat_i : '0;
    assign csr_we_o = grant_acc & wants_wr & ~illegal;

    // Trap and return strobes to the register block
    assign trap_take_o  = grant_ex | grant_irq;
    assign trap_irq_o   = grant_irq;
    assign mret_o       = grant_mret;
    assign trap_cause_o = grant_irq ? irq_cause_i : ex_cause_i;
    assign trap_o       = trap_take_o;

    // Exceptions always go to the plain base
    always_comb begin
        if (grant_ex) begin
            trap_vec_o = {mtvec_i[`CSR_XLEN-1:2], 2'b00};
        end else if (grant_irq) begin
            trap_vec_o = irq_vec_i;
        end else begin
            trap_vec_o = '0;
        end
    end

endmodule

// ==== csr_irq.sv ====
// Interrupt masking, priority selection and trap handler address
`include "csr_defs.svh"

module csr_irq (
    input  csr_pkg::irq_lines_t irq_i,
    input  logic                mie_i,
    input  csr_pkg::xlen_t      mie_en_i,
    input  csr_pkg::xlen_t      mtvec_i,

    output logic                pend_o,
    output csr_pkg::cause_t     cause_o,
    output csr_pkg::xlen_t      vec_o
);

    csr_pkg::irq_lines_t act;
    csr_pkg::xlen_t      base;

    // Lines gated by their individual enables
    assign act[0] = irq_i[0] & mie_en_i[`CSR_IRQ_MSI];
    assign act[1] = irq_i[1] & mie_en_i[`CSR_IRQ_MTI];
    assign act[2] = irq_i[2] & mie_en_i[`CSR_IRQ_MEI];

    // Global enable from mstatus
    assign pend_o = mie_i & (|act);

    // External first, then software, then timer
    always_comb begin
        if (act[2]) begin
            cause_o = csr_pkg::cause_t'(`CSR_IRQ_MEI);
        end else if (act[0]) begin
            cause_o = csr_pkg::cause_t'(`CSR_IRQ_MSI);
        end else if (act[1]) begin
            cause_o = csr_pkg::cause_t'(`CSR_IRQ_MTI);
        end else begin
            cause_o = '0;
        end
    end

    assign base = {mtvec_i[`CSR_XLEN-1:2], 2'b00};

    // Mode bit 0 selects vectored handlers at base + 4 * cause
    always_comb begin
        if (mtvec_i[0]) begin
            vec_o = base + csr_pkg::xlen_t'({cause_o, 2'b00});
        end else begin
            vec_o = base;
        end
    end

endmodule

// ==== csr_pkg.sv ====
// CSR unit package with the vector types shared across the design
`include "csr_defs.svh"

package csr_pkg;

    // Data word
    typedef logic [`CSR_XLEN-1:0] xlen_t;

    // CSR address from the instruction immediate
    typedef logic [11:0] csr_addr_t;

    // Instruction funct3 field
    typedef logic [2:0] funct3_t;

    // Trap cause code, interrupt flag is carried separately in mcause
    typedef logic [4:0] cause_t;

    // Machine interrupt lines
    // bit 0 software, bit 1 timer, bit 2 external
    typedef logic [2:0] irq_lines_t;

endpackage

// ==== csr_defs.svh ====
// CSR unit constants covering data width, funct3 codes, CSR map and fixed values
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_XLEN 32

// Zicsr funct3 codes
`define CSR_F3_RW   3'd1
`define CSR_F3_RS   3'd2
`define CSR_F3_RC   3'd3
`define CSR_F3_RWI  3'd5
`define CSR_F3_RSI  3'd6
`define CSR_F3_RCI  3'd7

// Machine CSR addresses
`define CSR_MSTATUS    12'h300
`define CSR_MISA       12'h301
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343
`define CSR_MIP        12'h344
`define CSR_MVENDORID  12'hF11
`define CSR_MARCHID    12'hF12
`define CSR_MIMPID     12'hF13
`define CSR_MHARTID    12'hF14

// Bit positions in mstatus and in mie/mip
`define CSR_MSTATUS_MIE   3
`define CSR_MSTATUS_MPIE  7
`define CSR_IRQ_MSI       3
`define CSR_IRQ_MTI       7
`define CSR_IRQ_MEI       11

// Fixed read values, misa is RV32I
`define CSR_MISA_VALUE       32'h4000_0100
`define CSR_MVENDORID_VALUE  32'h0000_0000
`define CSR_MARCHID_VALUE    32'h0000_0000
`define CSR_MIMPID_VALUE     32'h0000_0001
`define CSR_MHARTID_VALUE    32'h0000_0000

`endif
